// ==== src/axil_macros.svh ====
// AXI4-Lite memory path: bus widths, SRAM size and the fixed PROT value
`ifndef AXIL_MACROS_SVH
`define AXIL_MACROS_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define AXIL_DATA_W 64
`define AXIL_ADDR_W 32
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

// ----------------------------------------
// SRAM and protection
// ----------------------------------------
`define SRAM_DEPTH_WORDS 256      // 2 KiB of 64-bit words
`define AXIL_PROT_VAL 3'b000      // Unprivileged, secure, data access

`endif

// ==== src/axil_pkg.sv ====
// AXI4-Lite memory path package: response codes and requester select
package axil_pkg;

  // AXI response codes, as carried on BRESP and RRESP
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

  // Owner of the shared master
  typedef enum logic {
    SEL_IF  = 1'b0,   // Instruction fetch
    SEL_LSU = 1'b1    // Load/store unit
  } req_sel_e;

endpackage

// ==== src/mem_req_arbiter.sv ====
// Fixed-priority arbiter between fetch and load/store, locked for the whole transaction
`timescale 1ns/1ps
`include "axil_macros.svh"

module mem_req_arbiter (
  input  logic                       i_aclk,
  input  logic                       i_rst_n,
  // Fetch port
  input  logic                       i_if_valid,
  input  logic [`AXIL_ADDR_W-1:0]    i_if_addr,
  // Load/store port
  input  logic                       i_lsu_valid,
  input  logic                       i_lsu_wen,
  input  logic [`AXIL_ADDR_W-1:0]    i_lsu_addr,
  input  logic [`AXIL_DATA_W-1:0]    i_lsu_wdata,
  input  logic [`AXIL_STRB_W-1:0]    i_lsu_strb,
  output logic                       o_if_done,
  output logic                       o_lsu_done,
  // Toward the master
  output logic                       o_rw_valid,
  output logic                       o_rw_wen,
  output logic [`AXIL_ADDR_W-1:0]    o_rw_addr,
  output logic [`AXIL_DATA_W-1:0]    o_rw_wdata,
  output logic [`AXIL_STRB_W-1:0]    o_rw_strb,
  input  logic                       i_rw_done
);
  import axil_pkg::*;

  req_sel_e owner_q;
  req_sel_e sel_now;      // Winner if the arbiter were free this cycle
  req_sel_e cur_sel;
  logic     locked_q;

  assign sel_now = i_lsu_valid ? SEL_LSU : SEL_IF;   // LSU has priority
  assign cur_sel = locked_q ? owner_q : sel_now;

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      locked_q <= 1'b0;
      owner_q  <= SEL_IF;
    end else if (!locked_q && (i_if_valid || i_lsu_valid)) begin
      locked_q <= 1'b1;
      owner_q  <= sel_now;
    end else if (locked_q && i_rw_done) begin
      locked_q <= 1'b0;
    end
  end

  // Forwarded request
  always_comb begin
    if (cur_sel == SEL_LSU) begin
      o_rw_valid = i_lsu_valid;
      o_rw_wen   = i_lsu_wen;
      o_rw_addr  = i_lsu_addr;
      o_rw_wdata = i_lsu_wdata;
      o_rw_strb  = i_lsu_strb;
    end else begin
      o_rw_valid = i_if_valid;
      o_rw_wen   = 1'b0;           // Fetch only reads
      o_rw_addr  = i_if_addr;
      o_rw_wdata = '0;
      o_rw_strb  = '1;
    end
  end

  assign o_if_done  = i_rw_done & locked_q & (owner_q == SEL_IF);
  assign o_lsu_done = i_rw_done & locked_q & (owner_q == SEL_LSU);

endmodule

// ==== src/axil_master_wrap.sv ====
// AXI4-Lite master wrapper: turns one held request into a single read or write transaction
`timescale 1ns/1ps
`include "axil_macros.svh"

module axil_master_wrap (
  input  logic                       i_aclk,
  input  logic                       i_rst_n,
  // Request side
  input  logic                       i_rw_valid,
  input  logic                       i_rw_wen,
  input  logic [`AXIL_ADDR_W-1:0]    i_rw_addr,
  input  logic [`AXIL_DATA_W-1:0]    i_rw_wdata,
  input  logic [`AXIL_STRB_W-1:0]    i_rw_strb,
  output logic                       o_rw_done,
  output logic [`AXIL_DATA_W-1:0]    o_rw_rdata,
  output logic                       o_rw_err,
  // Write address channel
  output logic                       o_awvalid,
  input  logic                       i_awready,
  output logic [`AXIL_ADDR_W-1:0]    o_awaddr,
  output logic [2:0]                 o_awprot,
  // Write data channel
  output logic                       o_wvalid,
  input  logic                       i_wready,
  output logic [`AXIL_DATA_W-1:0]    o_wdata,
  output logic [`AXIL_STRB_W-1:0]    o_wstrb,
  // Write response channel
  input  logic                       i_bvalid,
  output logic                       o_bready,
  input  axil_pkg::axil_resp_e       i_bresp,
  // Read address channel
  output logic                       o_arvalid,
  input  logic                       i_arready,
  output logic [`AXIL_ADDR_W-1:0]    o_araddr,
  output logic [2:0]                 o_arprot,
  // Read data channel
  input  logic                       i_rvalid,
  output logic                       o_rready,
  input  logic [`AXIL_DATA_W-1:0]    i_rdata,
  input  axil_pkg::axil_resp_e       i_rresp
);
  import axil_pkg::*;

  typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_WRITE, WR_RESP} wr_state_e;
  typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_READ} rd_state_e;

  wr_state_e wr_state_q, wr_state_d;
  rd_state_e rd_state_q, rd_state_d;

  logic aw_fire, w_fire, b_fire, ar_fire, r_fire;
  logic start;

  assign aw_fire = o_awvalid & i_awready;
  assign w_fire  = o_wvalid  & i_wready;
  assign b_fire  = i_bvalid  & o_bready;
  assign ar_fire = o_arvalid & i_arready;
  assign r_fire  = i_rvalid  & o_rready;

  // The request is still up during the done cycle, so it must not restart
  assign start = i_rw_valid & ~o_rw_done & (wr_state_q == WR_IDLE) & (rd_state_q == RD_IDLE);

  // ----------------------------------------
  // State machines
  // ----------------------------------------
  always_comb begin
    wr_state_d = wr_state_q;
    case (wr_state_q)
      WR_IDLE:  if (start && i_rw_wen) wr_state_d = WR_ADDR;
      WR_ADDR:  if (aw_fire) wr_state_d = WR_WRITE;
      WR_WRITE: if (w_fire) wr_state_d = WR_RESP;
      WR_RESP:  if (b_fire) wr_state_d = WR_IDLE;
      default:  wr_state_d = WR_IDLE;
    endcase
  end

  always_comb begin
    rd_state_d = rd_state_q;
    case (rd_state_q)
      RD_IDLE: if (start && !i_rw_wen) rd_state_d = RD_ADDR;
      RD_ADDR: if (ar_fire) rd_state_d = RD_READ;
      RD_READ: if (r_fire) rd_state_d = RD_IDLE;
      default: rd_state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_state_q <= WR_IDLE;
      rd_state_q <= RD_IDLE;
      o_rw_done  <= 1'b0;
    end else begin
      wr_state_q <= wr_state_d;
      rd_state_q <= rd_state_d;
      o_rw_done  <= b_fire | r_fire;   // One pulse per transaction
    end
  end

  // ----------------------------------------
  // Channel outputs
  // ----------------------------------------
  assign o_awvalid = (wr_state_q == WR_ADDR);
  assign o_awaddr  = i_rw_addr;
  assign o_awprot  = `AXIL_PROT_VAL;

  assign o_wvalid  = (wr_state_q == WR_WRITE);
  assign o_wdata   = i_rw_wdata;
  assign o_wstrb   = i_rw_strb;
  assign o_bready  = (wr_state_q == WR_RESP);

  assign o_arvalid = (rd_state_q == RD_ADDR);
  assign o_araddr  = i_rw_addr;
  assign o_arprot  = `AXIL_PROT_VAL;
  assign o_rready  = (rd_state_q == RD_READ);

  // Result capture
  always_ff @(posedge i_aclk) begin
    if (r_fire) begin
      o_rw_rdata <= (i_rresp == OKAY) ? i_rdata : '0;   // Error reads return zero
      o_rw_err   <= (i_rresp != OKAY);
    end else if (b_fire) begin
      o_rw_err   <= (i_bresp != OKAY);
    end
  end

endmodule

// ==== src/axil_sram_slave.sv ====
// AXI4-Lite SRAM slave with byte strobes and SLVERR past the end of the array
`timescale 1ns/1ps
`include "axil_macros.svh"

module axil_sram_slave (
  input  logic                       i_aclk,
  input  logic                       i_rst_n,
  // Write address channel
  input  logic                       i_awvalid,
  output logic                       o_awready,
  input  logic [`AXIL_ADDR_W-1:0]    i_awaddr,
  // Write data channel
  input  logic                       i_wvalid,
  output logic                       o_wready,
  input  logic [`AXIL_DATA_W-1:0]    i_wdata,
  input  logic [`AXIL_STRB_W-1:0]    i_wstrb,
  // Write response channel
  output logic                       o_bvalid,
  input  logic                       i_bready,
  output axil_pkg::axil_resp_e       o_bresp,
  // Read address channel
  input  logic                       i_arvalid,
  output logic                       o_arready,
  input  logic [`AXIL_ADDR_W-1:0]    i_araddr,
  // Read data channel
  output logic                       o_rvalid,
  input  logic                       i_rready,
  output logic [`AXIL_DATA_W-1:0]    o_rdata,
  output axil_pkg::axil_resp_e       o_rresp
);
  import axil_pkg::*;

  localparam int IDX_W = $clog2(`SRAM_DEPTH_WORDS);
  localparam logic [`AXIL_ADDR_W-1:0] BYTE_LIMIT = `SRAM_DEPTH_WORDS * 8;

  logic [`AXIL_DATA_W-1:0] mem [`SRAM_DEPTH_WORDS];

  logic                    aw_fire, w_fire, b_fire, ar_fire, r_fire;
  logic                    aw_held;           // Address taken, data not yet
  logic [`AXIL_ADDR_W-1:0] aw_addr_q;
  logic                    wr_in_range, rd_in_range;
  logic [IDX_W-1:0]        wr_idx, rd_idx;

  assign aw_fire = i_awvalid & o_awready;
  assign w_fire  = i_wvalid  & o_wready;
  assign b_fire  = o_bvalid  & i_bready;
  assign ar_fire = i_arvalid & o_arready;
  assign r_fire  = o_rvalid  & i_rready;

  assign wr_in_range = (aw_addr_q < BYTE_LIMIT);
  assign rd_in_range = (i_araddr < BYTE_LIMIT);
  assign wr_idx      = aw_addr_q[IDX_W+2:3];   // Byte address / 8
  assign rd_idx      = i_araddr[IDX_W+2:3];

  assign o_wready = aw_held;

  // ----------------------------------------
  // Write path
  // ----------------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_awready <= 1'b0;
      aw_held   <= 1'b0;
      o_bvalid  <= 1'b0;
    end else begin
      // Ready again once the previous write has fully retired
      o_awready <= ~(aw_fire | aw_held | o_bvalid);
      if (aw_fire) aw_held <= 1'b1;
      else if (w_fire) aw_held <= 1'b0;
      if (w_fire) o_bvalid <= 1'b1;
      else if (b_fire) o_bvalid <= 1'b0;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (aw_fire) aw_addr_q <= i_awaddr;
    if (w_fire) begin
      o_bresp <= wr_in_range ? OKAY : SLVERR;
      if (wr_in_range) begin
        for (int b = 0; b < `AXIL_STRB_W; b++) begin
          if (i_wstrb[b]) mem[wr_idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  // ----------------------------------------
  // Read path
  // ----------------------------------------
  always_ff @(posedge i_aclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_arready <= 1'b0;
      o_rvalid  <= 1'b0;
    end else begin
      o_arready <= ~(ar_fire | o_rvalid);
      if (ar_fire) o_rvalid <= 1'b1;
      else if (r_fire) o_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      o_rdata <= rd_in_range ? mem[rd_idx] : '0;
      o_rresp <= rd_in_range ? OKAY : SLVERR;
    end
  end

endmodule

// ==== src/axil_mem_top.sv ====
// Memory side top: arbiter, AXI4-Lite master wrapper and SRAM slave
`timescale 1ns/1ps
`include "axil_macros.svh"

module axil_mem_top (
  input  logic                       i_aclk,
  input  logic                       i_rst_n,
  input  logic                       i_if_valid,
  input  logic [`AXIL_ADDR_W-1:0]    i_if_addr,
  input  logic                       i_lsu_valid,
  input  logic                       i_lsu_wen,
  input  logic [`AXIL_ADDR_W-1:0]    i_lsu_addr,
  input  logic [`AXIL_DATA_W-1:0]    i_lsu_wdata,
  input  logic [`AXIL_STRB_W-1:0]    i_lsu_strb,
  output logic                       o_if_done,
  output logic                       o_lsu_done,
  output logic [`AXIL_DATA_W-1:0]    o_rdata,   // Shared by both ports
  output logic                       o_err
);
  import axil_pkg::*;

  // ----------------------------------------
  // Arbiter to master
  // ----------------------------------------
  logic                    rw_valid, rw_wen, rw_done;
  logic [`AXIL_ADDR_W-1:0] rw_addr;
  logic [`AXIL_DATA_W-1:0] rw_wdata;
  logic [`AXIL_STRB_W-1:0] rw_strb;

  // AXI4-Lite between master and slave
  logic                    awvalid, awready, wvalid, wready, bvalid, bready;
  logic                    arvalid, arready, rvalid, rready;
  logic [`AXIL_ADDR_W-1:0] awaddr, araddr;
  logic [`AXIL_DATA_W-1:0] wdata, rdata;
  logic [`AXIL_STRB_W-1:0] wstrb;
  axil_resp_e              bresp, rresp;

  mem_req_arbiter u_arbiter (
    .i_aclk, .i_rst_n,
    .i_if_valid, .i_if_addr,
    .i_lsu_valid, .i_lsu_wen, .i_lsu_addr, .i_lsu_wdata, .i_lsu_strb,
    .o_if_done, .o_lsu_done,
    .o_rw_valid (rw_valid), .o_rw_wen (rw_wen), .o_rw_addr (rw_addr),
    .o_rw_wdata (rw_wdata), .o_rw_strb (rw_strb), .i_rw_done (rw_done)
  );

  axil_master_wrap u_master (
    .i_aclk, .i_rst_n,
    .i_rw_valid (rw_valid), .i_rw_wen (rw_wen), .i_rw_addr (rw_addr),
    .i_rw_wdata (rw_wdata), .i_rw_strb (rw_strb),
    .o_rw_done (rw_done), .o_rw_rdata (o_rdata), .o_rw_err (o_err),
    .o_awvalid (awvalid), .i_awready (awready), .o_awaddr (awaddr), .o_awprot (),
    .o_wvalid (wvalid), .i_wready (wready), .o_wdata (wdata), .o_wstrb (wstrb),
    .i_bvalid (bvalid), .o_bready (bready), .i_bresp (bresp),
    .o_arvalid (arvalid), .i_arready (arready), .o_araddr (araddr), .o_arprot (),
    .i_rvalid (rvalid), .o_rready (rready), .i_rdata (rdata), .i_rresp (rresp)
  );

  axil_sram_slave u_sram (
    .i_aclk, .i_rst_n,
    .i_awvalid (awvalid), .o_awready (awready), .i_awaddr (awaddr),
    .i_wvalid (wvalid), .o_wready (wready), .i_wdata (wdata), .i_wstrb (wstrb),
    .o_bvalid (bvalid), .i_bready (bready), .o_bresp (bresp),
    .i_arvalid (arvalid), .o_arready (arready), .i_araddr (araddr),
    .o_rvalid (rvalid), .i_rready (rready), .o_rdata (rdata), .o_rresp (rresp)
  );

endmodule

// ==== tb/tb_axil_mem_top.sv ====
// Testbench for the AXI4-Lite memory path: directed table, port race and random load/store
`timescale 1ns/1ps
`include "axil_macros.svh"

module tb_axil_mem_top;
  import axil_pkg::*;

  localparam int NUM_ENTRIES    = 14;
  localparam int NUM_RANDOM     = 40;
  localparam int TIMEOUT_CYCLES = 50;
  localparam int BYTE_LIMIT     = `SRAM_DEPTH_WORDS * 8;

  typedef struct packed {
    req_sel_e                port;
    logic                    wen;
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [`AXIL_DATA_W-1:0] wdata;
    logic [`AXIL_STRB_W-1:0] strb;
    logic [`AXIL_DATA_W-1:0] exp_rdata;
    logic                    exp_err;
  } entry_t;

  logic                    i_aclk, i_rst_n;
  logic                    i_if_valid, i_lsu_valid, i_lsu_wen;
  logic [`AXIL_ADDR_W-1:0] i_if_addr, i_lsu_addr;
  logic [`AXIL_DATA_W-1:0] i_lsu_wdata;
  logic [`AXIL_STRB_W-1:0] i_lsu_strb;
  logic                    o_if_done, o_lsu_done, o_err;
  logic [`AXIL_DATA_W-1:0] o_rdata;

  entry_t      stim_table [NUM_ENTRIES];
  logic [7:0]  shadow [BYTE_LIMIT];   // Byte image of the SRAM
  logic [31:0] lcg_state;

  axil_mem_top u_axil_mem_top (.*);

  initial begin
    i_aclk = 1'b0;
    forever #20 i_aclk = ~i_aclk;
  end

  // ----------------------------------------
  // Checking and models
  // ----------------------------------------
  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected) begin
      $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, expected);
      stop_with_failure();
    end
  endtask

  function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Zero past the end, like an SLVERR read
  function automatic logic [63:0] shadow_read(input logic [31:0] addr);
    logic [63:0] word;
    word = '0;
    if (addr < BYTE_LIMIT) begin
      for (int b = 0; b < 8; b++) word[b*8 +: 8] = shadow[{addr[10:3], 3'b000} + b];
    end
    return word;
  endfunction

  task automatic shadow_store(input logic [31:0] addr, input logic [63:0] data,
                              input logic [7:0] strb);
    if (addr < BYTE_LIMIT) begin
      for (int b = 0; b < 8; b++) begin
        if (strb[b]) shadow[{addr[10:3], 3'b000} + b] = data[b*8 +: 8];
      end
    end
  endtask

  // ----------------------------------------
  // Request drivers
  // ----------------------------------------
  task automatic run_request(input entry_t e, input int tag);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    if (e.port == SEL_LSU) begin
      i_lsu_wen   = e.wen;
      i_lsu_addr  = e.addr;
      i_lsu_wdata = e.wdata;
      i_lsu_strb  = e.strb;
      i_lsu_valid = 1'b1;
    end else begin
      i_if_addr  = e.addr;
      i_if_valid = 1'b1;
    end
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      @(negedge i_aclk);
      cycles++;
      seen = (e.port == SEL_LSU) ? o_lsu_done : o_if_done;
    end
    if (!seen) begin
      $display("Timeout: request %0d saw no done within %0d cycles", tag, TIMEOUT_CYCLES);
      stop_with_failure();
    end else begin
      if (!e.wen) check_value("o_rdata", o_rdata, e.exp_rdata);   // Writes leave o_rdata stale
      check_value("o_err", o_err, e.exp_err);
      i_lsu_valid = 1'b0;
      i_if_valid  = 1'b0;
      @(negedge i_aclk);
    end
  endtask

  // LSU write and fetch read raised together, LSU must finish first
  task automatic race_ports(input logic [31:0] addr, input logic [63:0] data);
    int   cycles;
    logic lsu_seen, if_seen;
    cycles      = 0;
    lsu_seen    = 1'b0;
    if_seen     = 1'b0;
    i_lsu_wen   = 1'b1;
    i_lsu_addr  = addr;
    i_lsu_wdata = data;
    i_lsu_strb  = '1;
    i_if_addr   = addr;
    i_lsu_valid = 1'b1;
    i_if_valid  = 1'b1;
    while (!(lsu_seen && if_seen) && cycles < TIMEOUT_CYCLES) begin
      @(negedge i_aclk);
      cycles++;
      if (o_lsu_done) begin
        check_value("o_err", o_err, 1'b0);
        i_lsu_valid = 1'b0;
        lsu_seen    = 1'b1;
      end
      if (o_if_done) begin
        check_value("o_lsu_done before o_if_done", lsu_seen, 1'b1);
        check_value("o_rdata", o_rdata, data);
        check_value("o_err", o_err, 1'b0);
        i_if_valid = 1'b0;
        if_seen    = 1'b1;
      end
    end
    if (!(lsu_seen && if_seen)) begin
      $display("Timeout: racing fetch and load/store requests did not both finish");
      stop_with_failure();
    end else begin
      @(negedge i_aclk);
    end
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    entry_t e;
    logic [31:0] r;
    i_rst_n     = 1'b0;
    i_if_valid  = 1'b0;
    i_if_addr   = '0;
    i_lsu_valid = 1'b0;
    i_lsu_wen   = 1'b0;
    i_lsu_addr  = '0;
    i_lsu_wdata = '0;
    i_lsu_strb  = '0;
    lcg_state   = 32'h66c5;

    stim_table[0]  = '{SEL_LSU, 1'b1, 32'h010, 64'h1122_3344_5566_7788, 8'hff, 64'h0, 1'b0};
    stim_table[1]  = '{SEL_LSU, 1'b0, 32'h010, 64'h0, 8'hff, 64'h1122_3344_5566_7788, 1'b0};
    stim_table[2]  = '{SEL_LSU, 1'b1, 32'h010, 64'hAABB_CCDD_EEFF_0011, 8'h3c, 64'h0, 1'b0};
    stim_table[3]  = '{SEL_LSU, 1'b0, 32'h010, 64'h0, 8'hff, 64'h1122_CCDD_EEFF_7788, 1'b0};
    stim_table[4]  = '{SEL_IF,  1'b0, 32'h010, 64'h0, 8'hff, 64'h1122_CCDD_EEFF_7788, 1'b0};
    stim_table[5]  = '{SEL_LSU, 1'b1, 32'h018, 64'h0123_4567_89AB_CDEF, 8'hff, 64'h0, 1'b0};
    stim_table[6]  = '{SEL_IF,  1'b0, 32'h018, 64'h0, 8'hff, 64'h0123_4567_89AB_CDEF, 1'b0};
    stim_table[7]  = '{SEL_LSU, 1'b1, 32'h000, 64'h5555_AAAA_5555_AAAA, 8'hff, 64'h0, 1'b0};
    stim_table[8]  = '{SEL_LSU, 1'b1, 32'h800, 64'hDEAD_BEEF_DEAD_BEEF, 8'hff, 64'h0, 1'b1};
    stim_table[9]  = '{SEL_LSU, 1'b0, 32'h800, 64'h0, 8'hff, 64'h0, 1'b1};
    stim_table[10] = '{SEL_IF,  1'b0, 32'h1000, 64'h0, 8'hff, 64'h0, 1'b1};
    stim_table[11] = '{SEL_LSU, 1'b1, 32'h7f8, 64'h0F1E_2D3C_4B5A_6978, 8'hff, 64'h0, 1'b0};
    stim_table[12] = '{SEL_LSU, 1'b0, 32'h000, 64'h0, 8'hff, 64'h5555_AAAA_5555_AAAA, 1'b0};
    stim_table[13] = '{SEL_LSU, 1'b0, 32'h7f8, 64'h0, 8'hff, 64'h0F1E_2D3C_4B5A_6978, 1'b0};

    repeat (10) @(negedge i_aclk);
    i_rst_n = 1'b1;

    // Quiet outputs before any request
    for (int c = 0; c < 8; c++) begin
      @(negedge i_aclk);
      check_value("o_if_done", o_if_done, 1'b0);
      check_value("o_lsu_done", o_lsu_done, 1'b0);
    end

    for (int n = 0; n < NUM_ENTRIES; n++) run_request(stim_table[n], n);

    race_ports(32'h020, 64'hCAFE_F00D_1234_5678);

    // Preload a 16-word window so the shadow holds no unknown bytes
    for (int w = 0; w < 16; w++) begin
      e.port        = SEL_LSU;
      e.wen         = 1'b1;
      e.addr        = w * 8;
      e.wdata[63:32] = rand32();
      e.wdata[31:0]  = rand32();
      e.strb        = 8'hff;
      e.exp_rdata   = '0;
      e.exp_err     = 1'b0;
      run_request(e, 200 + w);
      shadow_store(e.addr, e.wdata, e.strb);
    end

    for (int i = 0; i < NUM_RANDOM; i++) begin
      r              = rand32();
      e.port         = SEL_LSU;
      e.wen          = r[0];
      e.addr         = (r[7:4] == 4'h0) ? (32'h800 | {r[23:20], 3'b000})
                                        : {25'd0, r[19:16], 3'b000};
      e.wdata[63:32] = rand32();
      e.wdata[31:0]  = rand32();
      e.strb         = r[31:24];
      e.exp_err      = (e.addr >= BYTE_LIMIT);
      e.exp_rdata    = shadow_read(e.addr);
      run_request(e, 300 + i);
      if (e.wen) shadow_store(e.addr, e.wdata, e.strb);
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+src
src/axil_pkg.sv
src/mem_req_arbiter.sv
src/axil_master_wrap.sv
src/axil_sram_slave.sv
src/axil_mem_top.sv
tb/tb_axil_mem_top.sv

// ==== Bender.yml ====
package:
  name: axil_mem

export_include_dirs:
  - src

sources:
  - files:
      - src/axil_pkg.sv
      - src/mem_req_arbiter.sv
      - src/axil_master_wrap.sv
      - src/axil_sram_slave.sv
      - src/axil_mem_top.sv
  - target: test
    files:
      - tb/tb_axil_mem_top.sv
